// ==== project.f ====
+incdir+.
clock_pkg.sv
tick_prescaler.sv
set_controller.sv
time_counter.sv
date_counter.sv
display.sv
digital_clock.sv
tb_digital_clock.sv

// ==== tb_digital_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clock_consts.svh"

module tb_digital_clock;

    import clock_pkg::*;

    localparam int cycle_limit = 20000;

    logic        clk_ctl, rst_n, mode, switch_time, switch_day, set_req;
    set_target_t set_target;
    logic [7:0]  set_hi, set_mid;
    logic [15:0] set_wide;
    logic        set_ack;
    seg_t        seg;
    anode_t      anode;
    int          cycles;
    int          ack_cycle;

    digital_clock #(.ticks_per_sec(4)) DUT (
        .clk_ctl(clk_ctl), .rst_n(rst_n), .mode(mode), .switch_time(switch_time),
        .switch_day(switch_day), .set_req(set_req), .set_target(set_target),
        .set_hi(set_hi), .set_mid(set_mid), .set_wide(set_wide), .set_ack(set_ack),
        .seg(seg), .anode(anode)
    );

    initial
    begin
        clk_ctl = 1'b0;
        forever #4 clk_ctl = ~clk_ctl;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string name, input int expected, input int actual);
        if (expected !== actual)
            stop_run($sformatf("Error: %s expected %0d actual %0d", name, expected, actual));
    endtask

    always @(posedge clk_ctl)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
            stop_run("Timeout: the tests did not finish within the cycle limit");
    end

    ////////////////////////////////////////
    // Display reading
    ////////////////////////////////////////

    // Inverse of the segment table, 15 for blank or unknown
    function automatic int seg_to_digit(input seg_t code);
        case (code)
            `SEG_DIGIT_0: return 0;
            `SEG_DIGIT_1: return 1;
            `SEG_DIGIT_2: return 2;
            `SEG_DIGIT_3: return 3;
            `SEG_DIGIT_4: return 4;
            `SEG_DIGIT_5: return 5;
            `SEG_DIGIT_6: return 6;
            `SEG_DIGIT_7: return 7;
            `SEG_DIGIT_8: return 8;
            `SEG_DIGIT_9: return 9;
            default:      return 15;
        endcase
    endfunction

    task automatic read_digit(input anode_t pattern, output int value);
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk_ctl);
            if (anode == pattern)
            begin
                value = seg_to_digit(seg);
                return;
            end
        end
        stop_run($sformatf("Anode pattern %b never showed on the display", pattern));
    endtask

    task automatic expect_digits(input string name, input int e0, input int e1,
                                 input int e2, input int e3);
        int d0, d1, d2, d3;
        read_digit(`ANODE_0, d0);
        read_digit(`ANODE_1, d1);
        read_digit(`ANODE_2, d2);
        read_digit(`ANODE_3, d3);
        check({name, " digit 0"}, e0, d0);
        check({name, " digit 1"}, e1, d1);
        check({name, " digit 2"}, e2, d2);
        check({name, " digit 3"}, e3, d3);
    endtask

    // Tens read on both sides of the ones, so a carry in between is retried
    task automatic read_seconds(output int value);
        int ten_a, one, ten_b;
        do
        begin
            read_digit(`ANODE_1, ten_a);
            read_digit(`ANODE_0, one);
            read_digit(`ANODE_1, ten_b);
        end
        while (ten_a != ten_b);
        value = ten_a * 10 + one;
    endtask

    task automatic select_view(input view_t view);
        @(negedge clk_ctl);
        {switch_day, switch_time} = view;
        repeat (2) @(negedge clk_ctl);
    endtask

    ////////////////////////////////////////
    // Set handshake
    ////////////////////////////////////////

    task automatic do_set(input set_target_t target, input logic [7:0] hi,
                          input logic [7:0] mid, input logic [15:0] wide, input int hold);
        int waited;
        @(negedge clk_ctl);
        set_target = target;
        set_hi     = hi;
        set_mid    = mid;
        set_wide   = wide;
        set_req    = 1'b1;
        waited     = 0;
        while (!set_ack)
        begin
            @(negedge clk_ctl);
            waited++;
            if (waited > 10)
                stop_run("set_ack did not rise within 10 cycles of set_req");
        end
        ack_cycle = cycles;
        repeat (hold)
        begin
            @(negedge clk_ctl);
            check("ack held high", 1, set_ack);
        end
        set_req = 1'b0;
        waited  = 0;
        while (set_ack)
        begin
            @(negedge clk_ctl);
            waited++;
            if (waited > 10)
                stop_run("set_ack did not fall after set_req was released");
        end
    endtask

    task automatic set_time(input logic [7:0] h, input logic [7:0] m, input logic [7:0] s,
                            input int hold);
        do_set(TARGET_TIME, h, m, {8'h00, s}, hold);
    endtask

    task automatic set_date(input logic [7:0] d, input logic [7:0] m, input logic [15:0] y);
        do_set(TARGET_DATE, d, m, y, 0);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_reset_state();
        check("reset ack", 0, set_ack);
        select_view(VIEW_DM);
        expect_digits("reset date", 1, 0, 1, 0);
        select_view(VIEW_YEAR);
        expect_digits("reset year", 0, 0, 0, 2);
    endtask

    task automatic test_hour_forms();
        select_view(VIEW_HM);
        set_time(8'h13, 8'h45, 8'h00, 0);
        expect_digits("13:45 24h", 5, 4, 3, 1);
        mode = 1'b0;
        repeat (2) @(negedge clk_ctl);
        expect_digits("13:45 12h", 5, 4, 1, 0);
        set_time(8'h00, 8'h10, 8'h00, 0);
        expect_digits("00:10 12h", 0, 1, 2, 1);
        mode = 1'b1;
    endtask

    task automatic test_seconds_view();
        int s1, s2, c1, c2, want, grown;
        set_time(8'h12, 8'h00, 8'h00, 0);
        select_view(VIEW_SEC);
        repeat (16)
        begin
            @(negedge clk_ctl);
            check("seconds view anode", 0, int'(anode == `ANODE_2 || anode == `ANODE_3));
            if (anode == `ANODE_NONE)
                check("seconds view blank", 15, seg_to_digit(seg));
        end
        read_seconds(s1);
        c1 = cycles;
        repeat (40) @(negedge clk_ctl);
        read_seconds(s2);
        c2 = cycles;
        want  = (c2 - c1) / 4;
        grown = s2 - s1;
        // One second of slack for the tick phase
        if (grown >= want - 1 && grown <= want + 1)
            want = grown;
        check("seconds rate", want, grown);
    endtask

    task automatic leap_case(input string name, input logic [15:0] year,
                             input int e0, input int e1, input int e2, input int e3);
        int sec;
        set_date(8'h28, 8'h02, year);
        set_time(8'h23, 8'h59, 8'h58, 0);
        select_view(VIEW_SEC);
        // Loaded at 58, so a smaller value means midnight has passed
        do
            read_seconds(sec);
        while (sec >= 58);
        select_view(VIEW_DM);
        expect_digits(name, e0, e1, e2, e3);
    endtask

    task automatic test_year_rollover();
        int sec;
        set_date(8'h31, 8'h12, 16'h2099);
        set_time(8'h23, 8'h59, 8'h59, 0);
        select_view(VIEW_SEC);
        do
            read_seconds(sec);
        while (sec >= 58);
        select_view(VIEW_DM);
        expect_digits("new year date", 1, 0, 1, 0);
        select_view(VIEW_YEAR);
        expect_digits("new year", 0, 0, 1, 2);
    endtask

    task automatic test_held_request();
        int sec, want;
        select_view(VIEW_SEC);
        set_time(8'h10, 8'h20, 8'h30, 20);
        read_seconds(sec);
        want = 30 + (cycles - ack_cycle) / 4;
        if (sec >= want - 1 && sec <= want + 1)
            want = sec;
        check("held request seconds", want, sec);
    endtask

    initial
    begin
        cycles      = 0;
        ack_cycle   = 0;
        rst_n       = 1'b0;
        mode        = 1'b1;
        switch_time = 1'b0;
        switch_day  = 1'b0;
        set_req     = 1'b0;
        set_target  = TARGET_TIME;
        set_hi      = 8'h00;
        set_mid     = 8'h00;
        set_wide    = 16'h0000;
        repeat (16) @(negedge clk_ctl);
        rst_n = 1'b1;

        test_reset_state();
        test_hour_forms();
        test_seconds_view();
        leap_case("leap 2024", 16'h2024, 9, 2, 2, 0);
        leap_case("no leap 2100", 16'h2100, 1, 0, 3, 0);
        leap_case("leap 2000", 16'h2000, 9, 2, 2, 0);
        test_year_rollover();
        test_held_request();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== digital_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clock_consts.svh"

module digital_clock #(
    parameter int ticks_per_sec = `DEFAULT_TICKS_PER_SEC
) (
    input  logic                   clk_ctl,
    input  logic                   rst_n,
    input  logic                   mode,
    input  logic                   switch_time,
    input  logic                   switch_day,
    input  logic                   set_req,
    input  clock_pkg::set_target_t set_target,
    input  logic [7:0]             set_hi,
    input  logic [7:0]             set_mid,
    input  logic [15:0]            set_wide,
    output logic                   set_ack,
    output clock_pkg::seg_t        seg,
    output clock_pkg::anode_t      anode
);

    import clock_pkg::*;

    logic        sec_tick, day_tick, load_time, load_date;
    logic [7:0]  load_hi, load_mid;
    logic [15:0] load_wide;
    bcd_digit_t  hour_ten, hour_one, min_ten, min_one, sec_ten, sec_one;
    bcd_digit_t  day_ten, day_one, month_ten, month_one;
    bcd_digit_t  year_thu, year_hun, year_ten, year_one;

    tick_prescaler #(.ticks_per_sec(ticks_per_sec)) u_prescaler (
        .clk_ctl(clk_ctl), .rst_n(rst_n), .sec_tick(sec_tick)
    );

    set_controller u_set (
        .clk_ctl(clk_ctl), .rst_n(rst_n), .set_req(set_req), .set_target(set_target),
        .set_hi(set_hi), .set_mid(set_mid), .set_wide(set_wide), .set_ack(set_ack),
        .load_time(load_time), .load_date(load_date),
        .load_hi(load_hi), .load_mid(load_mid), .load_wide(load_wide)
    );

    // Seconds come from the low byte of the wide field
    time_counter u_time (
        .clk_ctl(clk_ctl), .rst_n(rst_n), .sec_tick(sec_tick), .load_time(load_time),
        .load_hi(load_hi), .load_mid(load_mid), .load_sec(load_wide[7:0]),
        .hour_ten(hour_ten), .hour_one(hour_one), .min_ten(min_ten), .min_one(min_one),
        .sec_ten(sec_ten), .sec_one(sec_one), .day_tick(day_tick)
    );

    date_counter u_date (
        .clk_ctl(clk_ctl), .rst_n(rst_n), .day_tick(day_tick), .load_date(load_date),
        .load_hi(load_hi), .load_mid(load_mid), .load_wide(load_wide),
        .day_ten(day_ten), .day_one(day_one), .month_ten(month_ten), .month_one(month_one),
        .year_thu(year_thu), .year_hun(year_hun), .year_ten(year_ten), .year_one(year_one)
    );

    display u_display (
        .clk_ctl(clk_ctl), .rst_n(rst_n), .mode(mode),
        .switch_time(switch_time), .switch_day(switch_day),
        .hour_ten(hour_ten), .hour_one(hour_one), .min_ten(min_ten), .min_one(min_one),
        .sec_ten(sec_ten), .sec_one(sec_one), .day_ten(day_ten), .day_one(day_one),
        .month_ten(month_ten), .month_one(month_one), .year_thu(year_thu),
        .year_hun(year_hun), .year_ten(year_ten), .year_one(year_one),
        .seg(seg), .anode(anode)
    );

endmodule

`default_nettype wire

// ==== display.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clock_consts.svh"

module display (
    input  logic                  clk_ctl,
    input  logic                  rst_n,
    input  logic                  mode,
    input  logic                  switch_time,
    input  logic                  switch_day,
    input  clock_pkg::bcd_digit_t hour_ten,
    input  clock_pkg::bcd_digit_t hour_one,
    input  clock_pkg::bcd_digit_t min_ten,
    input  clock_pkg::bcd_digit_t min_one,
    input  clock_pkg::bcd_digit_t sec_ten,
    input  clock_pkg::bcd_digit_t sec_one,
    input  clock_pkg::bcd_digit_t day_ten,
    input  clock_pkg::bcd_digit_t day_one,
    input  clock_pkg::bcd_digit_t month_ten,
    input  clock_pkg::bcd_digit_t month_one,
    input  clock_pkg::bcd_digit_t year_thu,
    input  clock_pkg::bcd_digit_t year_hun,
    input  clock_pkg::bcd_digit_t year_ten,
    input  clock_pkg::bcd_digit_t year_one,
    output clock_pkg::seg_t       seg,
    output clock_pkg::anode_t     anode
);

    import clock_pkg::*;

    view_t      view;
    logic [1:0] scan;
    logic [4:0] hour_bin, hour_12;
    bcd_digit_t show_ten, show_one, digit;
    logic       blank;
    anode_t     anode_next;

    function automatic seg_t seg_decode(input bcd_digit_t value);
        case (value)
            4'd0:    return `SEG_DIGIT_0;
            4'd1:    return `SEG_DIGIT_1;
            4'd2:    return `SEG_DIGIT_2;
            4'd3:    return `SEG_DIGIT_3;
            4'd4:    return `SEG_DIGIT_4;
            4'd5:    return `SEG_DIGIT_5;
            4'd6:    return `SEG_DIGIT_6;
            4'd7:    return `SEG_DIGIT_7;
            4'd8:    return `SEG_DIGIT_8;
            4'd9:    return `SEG_DIGIT_9;
            default: return `SEG_BLANK;
        endcase
    endfunction

    assign view = view_t'({switch_day, switch_time});

    ////////////////////////////////////////
    // Hours in 12-hour form
    ////////////////////////////////////////

    // 00 shows as 12, 13 to 23 wrap down by 12
    assign hour_bin = {1'b0, hour_ten} * 5'd10 + {1'b0, hour_one};
    assign hour_12  = (hour_bin == 5'd0) ? 5'd12 :
                      (hour_bin > 5'd12) ? hour_bin - 5'd12 : hour_bin;
    assign show_ten = !mode ? ((hour_12 >= 5'd10) ? 4'd1 : 4'd0) : hour_ten;
    assign show_one = !mode ? 4'(hour_12 >= 5'd10 ? hour_12 - 5'd10 : hour_12) : hour_one;

    ////////////////////////////////////////
    // Digit select, rightmost digit first
    ////////////////////////////////////////

    always_comb
    begin
        digit = 4'd0;
        blank = 1'b0;
        case (view)
            VIEW_HM:
            begin
                case (scan)
                    2'd0:    digit = min_one;
                    2'd1:    digit = min_ten;
                    2'd2:    digit = show_one;
                    default: digit = show_ten;
                endcase
            end
            VIEW_SEC:
            begin
                case (scan)
                    2'd0:    digit = sec_one;
                    2'd1:    digit = sec_ten;
                    default: blank = 1'b1;
                endcase
            end
            VIEW_DM:
            begin
                case (scan)
                    2'd0:    digit = day_one;
                    2'd1:    digit = day_ten;
                    2'd2:    digit = month_one;
                    default: digit = month_ten;
                endcase
            end
            default:
            begin
                case (scan)
                    2'd0:    digit = year_one;
                    2'd1:    digit = year_ten;
                    2'd2:    digit = year_hun;
                    default: digit = year_thu;
                endcase
            end
        endcase
    end

    always_comb
    begin
        case (scan)
            2'd0:    anode_next = `ANODE_0;
            2'd1:    anode_next = `ANODE_1;
            2'd2:    anode_next = `ANODE_2;
            default: anode_next = `ANODE_3;
        endcase
    end

    // Segment and anode leave the same register stage
    always_ff @(posedge clk_ctl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scan  <= 2'd0;
            seg   <= `SEG_BLANK;
            anode <= 4'b0000;
        end
        else
        begin
            scan  <= scan + 2'd1;
            seg   <= blank ? `SEG_BLANK : seg_decode(digit);
            anode <= blank ? `ANODE_NONE : anode_next;
        end
    end

endmodule

`default_nettype wire

// ==== date_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clock_consts.svh"

module date_counter (
    input  logic                  clk_ctl,
    input  logic                  rst_n,
    input  logic                  day_tick,
    input  logic                  load_date,
    input  logic [7:0]            load_hi,
    input  logic [7:0]            load_mid,
    input  logic [15:0]           load_wide,
    output clock_pkg::bcd_digit_t day_ten,
    output clock_pkg::bcd_digit_t day_one,
    output clock_pkg::bcd_digit_t month_ten,
    output clock_pkg::bcd_digit_t month_one,
    output clock_pkg::bcd_digit_t year_thu,
    output clock_pkg::bcd_digit_t year_hun,
    output clock_pkg::bcd_digit_t year_ten,
    output clock_pkg::bcd_digit_t year_one
);

    import clock_pkg::*;

    logic [7:0]  day_q, month_q, last_day, day_next, month_next;
    logic [15:0] year_q;
    logic        leap_year;

    // Two-digit BCD value divisible by 4
    function automatic logic bcd_div4(input bcd_digit_t ten, input bcd_digit_t one);
        if (ten[0])
            return (one == 4'd2) || (one == 4'd6);
        return (one == 4'd0) || (one == 4'd4) || (one == 4'd8);
    endfunction

    function automatic logic [15:0] bcd_inc16(input logic [15:0] value);
        logic [15:0] result;
        logic        carry;
        result = value;
        carry  = 1'b1;
        for (int i = 0; i < 4; i++)
        begin
            if (carry && result[4*i +: 4] == 4'd9)
                result[4*i +: 4] = 4'd0;
            else if (carry)
            begin
                result[4*i +: 4] = result[4*i +: 4] + 4'd1;
                carry = 1'b0;
            end
        end
        return result;
    endfunction

    ////////////////////////////////////////
    // Month length
    ////////////////////////////////////////

    // Century years leap only when the century is divisible by 4
    assign leap_year = (year_q[7:0] == 8'h00) ? bcd_div4(year_q[15:12], year_q[11:8])
                                              : bcd_div4(year_q[7:4], year_q[3:0]);

    always_comb
    begin
        case (month_q)
            8'h02:                      last_day = leap_year ? 8'h29 : 8'h28;
            8'h04, 8'h06, 8'h09, 8'h11: last_day = 8'h30;
            default:                    last_day = 8'h31;
        endcase
    end

    assign day_next   = (day_q[3:0] == 4'h9) ? {day_q[7:4] + 4'h1, 4'h0} : day_q + 8'h01;
    assign month_next = (month_q == 8'h09) ? 8'h10 : month_q + 8'h01;

    ////////////////////////////////////////
    // Calendar registers
    ////////////////////////////////////////

    always_ff @(posedge clk_ctl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            day_q   <= `RESET_DAY;
            month_q <= `RESET_MONTH;
            year_q  <= `RESET_YEAR;
        end
        else if (load_date)
        begin
            day_q   <= load_hi;
            month_q <= load_mid;
            year_q  <= load_wide;
        end
        else if (day_tick)
        begin
            if (day_q != last_day)
                day_q <= day_next;
            else
            begin
                day_q <= 8'h01;
                if (month_q == 8'h12)
                begin
                    month_q <= 8'h01;
                    year_q  <= bcd_inc16(year_q);
                end
                else
                    month_q <= month_next;
            end
        end
    end

    assign day_ten   = day_q[7:4];
    assign day_one   = day_q[3:0];
    assign month_ten = month_q[7:4];
    assign month_one = month_q[3:0];
    assign year_thu  = year_q[15:12];
    assign year_hun  = year_q[11:8];
    assign year_ten  = year_q[7:4];
    assign year_one  = year_q[3:0];

endmodule

`default_nettype wire

// ==== time_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module time_counter (
    input  logic                  clk_ctl,
    input  logic                  rst_n,
    input  logic                  sec_tick,
    input  logic                  load_time,
    input  logic [7:0]            load_hi,
    input  logic [7:0]            load_mid,
    input  logic [7:0]            load_sec,
    output clock_pkg::bcd_digit_t hour_ten,
    output clock_pkg::bcd_digit_t hour_one,
    output clock_pkg::bcd_digit_t min_ten,
    output clock_pkg::bcd_digit_t min_one,
    output clock_pkg::bcd_digit_t sec_ten,
    output clock_pkg::bcd_digit_t sec_one,
    output logic                  day_tick
);

    import clock_pkg::*;

    logic sec_one_max, sec_max, min_one_max, min_max, hour_max;

    // Carry terms of the BCD cascade
    assign sec_one_max = (sec_one == 4'd9);
    assign sec_max     = sec_one_max && (sec_ten == 4'd5);
    assign min_one_max = (min_one == 4'd9);
    assign min_max     = min_one_max && (min_ten == 4'd5);
    assign hour_max    = (hour_ten == 4'd2) && (hour_one == 4'd3);

    // 23:59:59 is showing and the second is ending
    assign day_tick = sec_tick && sec_max && min_max && hour_max;

    always_ff @(posedge clk_ctl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hour_ten <= '0;
            hour_one <= '0;
            min_ten  <= '0;
            min_one  <= '0;
            sec_ten  <= '0;
            sec_one  <= '0;
        end
        else if (load_time)
        begin
            hour_ten <= load_hi[7:4];
            hour_one <= load_hi[3:0];
            min_ten  <= load_mid[7:4];
            min_one  <= load_mid[3:0];
            sec_ten  <= load_sec[7:4];
            sec_one  <= load_sec[3:0];
        end
        else if (sec_tick)
        begin
            sec_one <= sec_one_max ? 4'd0 : sec_one + 4'd1;
            if (sec_one_max)
                sec_ten <= (sec_ten == 4'd5) ? 4'd0 : sec_ten + 4'd1;
            if (sec_max)
                min_one <= min_one_max ? 4'd0 : min_one + 4'd1;
            if (sec_max && min_one_max)
                min_ten <= (min_ten == 4'd5) ? 4'd0 : min_ten + 4'd1;
            if (sec_max && min_max)
            begin
                if (hour_max)
                begin
                    hour_ten <= 4'd0;
                    hour_one <= 4'd0;
                end
                else if (hour_one == 4'd9)
                begin
                    hour_ten <= hour_ten + 4'd1;
                    hour_one <= 4'd0;
                end
                else
                    hour_one <= hour_one + 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== set_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module set_controller (
    input  logic                   clk_ctl,
    input  logic                   rst_n,
    input  logic                   set_req,
    input  clock_pkg::set_target_t set_target,
    input  logic [7:0]             set_hi,
    input  logic [7:0]             set_mid,
    input  logic [15:0]            set_wide,
    output logic                   set_ack,
    output logic                   load_time,
    output logic                   load_date,
    output logic [7:0]             load_hi,
    output logic [7:0]             load_mid,
    output logic [15:0]            load_wide
);

    import clock_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_ACK, ST_RELEASE} state_t;

    state_t      state;
    set_target_t target_q;

    // Fields taken on the edge that first sees the request
    always_ff @(posedge clk_ctl)
    begin
        if (state == ST_IDLE && set_req)
        begin
            target_q  <= set_target;
            load_hi   <= set_hi;
            load_mid  <= set_mid;
            load_wide <= set_wide;
        end
    end

    ////////////////////////////////////////
    // Four-phase handshake FSM
    ////////////////////////////////////////

    always_ff @(posedge clk_ctl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= ST_IDLE;
            set_ack   <= 1'b0;
            load_time <= 1'b0;
            load_date <= 1'b0;
        end
        else
        begin
            // Loads are single-cycle pulses
            load_time <= 1'b0;
            load_date <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (set_req)
                        state <= ST_LOAD;
                end
                ST_LOAD:
                begin
                    load_time <= (target_q == TARGET_TIME);
                    load_date <= (target_q == TARGET_DATE);
                    state     <= ST_ACK;
                end
                ST_ACK:
                begin
                    set_ack <= 1'b1;
                    state   <= ST_RELEASE;
                end
                default:
                begin
                    // Held request just keeps ack up
                    if (!set_req)
                    begin
                        set_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tick_prescaler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clock_consts.svh"

module tick_prescaler #(
    parameter int ticks_per_sec = `DEFAULT_TICKS_PER_SEC
) (
    input  logic clk_ctl,
    input  logic rst_n,
    output logic sec_tick
);

    localparam int cnt_w = (ticks_per_sec > 1) ? $clog2(ticks_per_sec) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(ticks_per_sec - 1);

    logic [cnt_w-1:0] cnt;

    // One pulse on the last count of each period
    assign sec_tick = (cnt == cnt_last);

    always_ff @(posedge clk_ctl or negedge rst_n)
    begin
        if (!rst_n)
            cnt <= '0;
        else if (sec_tick)
            cnt <= '0;
        else
            cnt <= cnt + cnt_w'(1);
    end

endmodule

`default_nettype wire

// ==== clock_pkg.sv ====
`default_nettype none

package clock_pkg;

    // One decimal digit
    typedef logic [3:0] bcd_digit_t;

    // Segments a to g in bits 0 to 6, dp in bit 7, active low
    typedef logic [7:0] seg_t;

    // Digit enables, active low
    typedef logic [3:0] anode_t;

    // Encoding matches {switch_day, switch_time}
    typedef enum logic [1:0] {
        VIEW_HM   = 2'b00,
        VIEW_SEC  = 2'b01,
        VIEW_DM   = 2'b10,
        VIEW_YEAR = 2'b11
    } view_t;

    typedef enum logic {
        TARGET_TIME = 1'b0,
        TARGET_DATE = 1'b1
    } set_target_t;

endpackage

`default_nettype wire

// ==== clock_consts.svh ====
`ifndef CLOCK_CONSTS_SVH
`define CLOCK_CONSTS_SVH

// Active-low segments, a in bit 0, decimal point in bit 7 kept off
`define SEG_BLANK   8'hFF
`define SEG_DIGIT_0 8'hC0
`define SEG_DIGIT_1 8'hF9
`define SEG_DIGIT_2 8'hA4
`define SEG_DIGIT_3 8'hB0
`define SEG_DIGIT_4 8'h99
`define SEG_DIGIT_5 8'h92
`define SEG_DIGIT_6 8'h82
`define SEG_DIGIT_7 8'hF8
`define SEG_DIGIT_8 8'h80
`define SEG_DIGIT_9 8'h90

// Active-low digit enables, digit 0 is the rightmost
`define ANODE_0    4'b1110
`define ANODE_1    4'b1101
`define ANODE_2    4'b1011
`define ANODE_3    4'b0111
`define ANODE_NONE 4'b1111

// Calendar start, packed BCD
`define RESET_DAY   8'h01
`define RESET_MONTH 8'h01
`define RESET_YEAR  16'h2000

// Board oscillator at 100 MHz
`define DEFAULT_TICKS_PER_SEC 100000000

`endif
